/* list.f */
source/zport_pkg.sv
source/io_strobe.sv
source/port_decode.sv
source/ula_port.sv
source/paging_ports.sv
source/evo_config_port.sv
source/zports_top.sv
tb/zports_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the port block testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module zports_tb -o zports_sim \
	&& ./obj_dir/zports_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

/* source/evo_config_port.sv */
////////////////////
// evo config port bf and readback port be
// be write also ends the nmi request
////////////////////
`timescale 1ns/1ps

module evo_config_port
(
	input  logic                         zclk,
	input  logic                         rst_n,
	input  zport_pkg::port_sel_e         port_sel,
	input  logic                         port_wr,
	input  logic [zport_pkg::DATA_W-1:0] din,
	input  logic                         dos,
	input  logic [3:0]                   a_hi,      // a[11:8]
	input  logic [zport_pkg::DATA_W-1:0] p7ffd_raw,
	input  logic [zport_pkg::DATA_W-1:0] peff7_raw,
	output logic                         shadow,
	output logic                         romrw_en,
	output logic                         fntw_en,
	output logic                         set_nmi,
	output logic [zport_pkg::DATA_W-1:0] bf_rdata,
	output logic [zport_pkg::DATA_W-1:0] be_rdata
);

	import zport_pkg::*;

	logic shadow_en;
	logic bf_wr;
	logic be_wr;

	assign bf_wr = (port_sel == SEL_BF) && port_wr;
	assign be_wr = (port_sel == SEL_BE) && port_wr;

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			fntw_en   <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else if (bf_wr)
		begin
			shadow_en <= din[0];
			romrw_en  <= din[1];
			fntw_en   <= din[2];
			set_nmi   <= din[3];
		end
		else if (be_wr)
			set_nmi <= 1'b0; // nmi handler done
	end

	assign shadow   = dos | shadow_en;
	assign bf_rdata = {4'b0000, set_nmi, fntw_en, romrw_en, shadow_en};

	always_comb
	begin
		case (a_hi)
			BE_SEL_7FFD: be_rdata = p7ffd_raw;
			BE_SEL_EFF7: be_rdata = peff7_raw;
			default:     be_rdata = BUS_IDLE;
		endcase
	end

	a_be_clears_nmi : assert property (@(posedge zclk) disable iff (!rst_n)
		be_wr |=> !set_nmi)
		else $error("set_nmi survived a be write");

endmodule

/* source/io_strobe.sv */
////////////////////
// z80 i/o strobe edge detector
// one-cycle port_wr/port_rd pulses for the port peers
////////////////////
`timescale 1ns/1ps

module io_strobe
(
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic       wr_lvl;
	logic       rd_lvl;
	logic [1:0] wr_q; // [0] newest sample
	logic [1:0] rd_q;

	assign wr_lvl = ~(iorq_n | wr_n);
	assign rd_lvl = ~(iorq_n | rd_n);

	// first edge samples the level, second one fires the pulse
	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_q    <= 2'b00;
			rd_q    <= 2'b00;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			wr_q    <= {wr_q[0], wr_lvl};
			rd_q    <= {rd_q[0], rd_lvl};
			port_wr <= wr_lvl & wr_q[0] & ~wr_q[1];
			port_rd <= rd_lvl & rd_q[0] & ~rd_q[1];
		end
	end

	a_no_rd_wr_overlap : assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd))
		else $error("port_wr and port_rd active together");

endmodule

/* source/paging_ports.sv */
////////////////////
// 7ffd and eff7 memory paging registers
// 48k lock, 1m lock and rom bit reload after reset
////////////////////
`timescale 1ns/1ps

module paging_ports
#(
	parameter int RST_SYNC_STAGES = zport_pkg::RST_SYNC_DEF
)
(
	input  logic                         zclk,
	input  logic                         rst_n,
	input  zport_pkg::port_sel_e         port_sel,
	input  logic                         port_wr,
	input  logic [zport_pkg::DATA_W-1:0] din,
	input  logic                         rstrom,
	output logic [zport_pkg::DATA_W-1:0] p7ffd,
	output logic [zport_pkg::DATA_W-1:0] peff7,
	output logic [zport_pkg::DATA_W-1:0] p7ffd_raw,
	output logic [zport_pkg::DATA_W-1:0] peff7_raw,
	output logic [5:0]                   pent1m_page,
	output logic [zport_pkg::DATA_W-1:0] paging_rdata
);

	import zport_pkg::*;

	logic [2:0] p7ffd_hi; // 7..5 extra page bits, bit 5 is the 48k lock
	logic       rom_q;    // 7ffd bit 4
	logic [3:0] p7ffd_lo; // 3 screen, 2..0 page
	logic [DATA_W-1:0] peff7_q;
	logic [RST_SYNC_STAGES-1:0] rst_sync;
	logic rom_reload;
	logic lock_1m;
	logic lock_7ffd;
	logic wr_7ffd;
	logic wr_eff7;

	if (RST_SYNC_STAGES < 2)
	begin : g_bad_sync
		$error("RST_SYNC_STAGES must be at least 2");
	end

	// reset synchronizer, held set during reset
	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			rst_sync <= '1;
		else
			rst_sync <= {rst_sync[RST_SYNC_STAGES-2:0], 1'b0};
	end

	assign rom_reload = rst_sync[RST_SYNC_STAGES-1];

	assign lock_1m   = peff7_q[2];
	assign lock_7ffd = p7ffd_hi[0] & lock_1m;
	assign wr_7ffd   = (port_sel == SEL_7FFD) && port_wr && !lock_7ffd;
	assign wr_eff7   = (port_sel == SEL_EFF7) && port_wr;

	////////////////////
	// registers
	////////////////////
	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_hi <= '0;
			p7ffd_lo <= '0;
			peff7_q  <= '0;
		end
		else
		begin
			if (wr_7ffd)
			begin
				p7ffd_hi <= din[7:5];
				p7ffd_lo <= din[3:0];
			end
			if (wr_eff7)
				peff7_q <= din;
		end
	end

	// rom bit tracks rstrom until the synchronizer lets go
	always_ff @(posedge zclk)
	begin
		if (rom_reload)
			rom_q <= rstrom;
		else if (wr_7ffd)
			rom_q <= din[4];
	end

	assign p7ffd_raw = {p7ffd_hi, rom_q, p7ffd_lo};
	assign peff7_raw = peff7_q;

	assign p7ffd = {(lock_1m ? 3'b000 : p7ffd_hi), rom_q, p7ffd_lo};
	assign peff7 = lock_1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	assign pent1m_page  = {p7ffd_hi, p7ffd_lo[2:0]};
	assign paging_rdata = BUS_IDLE; // write-only ports

	a_locked_7ffd : assert property (@(posedge zclk) disable iff (!rst_n)
		(port_sel == SEL_7FFD && port_wr && lock_7ffd && !rom_reload) |=> $stable(p7ffd_raw))
		else $error("locked 7ffd write changed the register");

endmodule

/* source/port_decode.sv */
////////////////////
// address decoder and shared read bus
// names the target port and muxes its byte onto dout
////////////////////
`timescale 1ns/1ps

module port_decode
(
	input  logic [zport_pkg::ADDR_W-1:0] a,
	input  logic                         iorq_n,
	input  logic                         rd_n,
	input  logic                         shadow,
	input  logic [zport_pkg::DATA_W-1:0] fe_rdata,
	input  logic [zport_pkg::DATA_W-1:0] paging_rdata,
	input  logic [zport_pkg::DATA_W-1:0] bf_rdata,
	input  logic [zport_pkg::DATA_W-1:0] be_rdata,
	output zport_pkg::port_sel_e         port_sel,
	output logic                         porthit,
	output logic                         dataout,
	output logic [zport_pkg::DATA_W-1:0] dout
);

	import zport_pkg::*;

	logic [7:0] loa;

	assign loa = a[7:0];

	////////////////////
	// port select
	////////////////////
	always_comb
	begin
		port_sel = SEL_NONE;
		case (loa)
			PORT_FE:
				port_sel = SEL_FE;
			PORT_FD:
				if (!a[15])
					port_sel = SEL_7FFD; // fffd/bffd belong to the ay
			PORT_F7:
				if (a[8] && !a[12] && !shadow)
					port_sel = SEL_EFF7; // eff7 hidden in shadow mode
			PORT_BF:
				port_sel = SEL_BF;
			PORT_BE:
				port_sel = SEL_BE;
			default:
				port_sel = SEL_NONE;
		endcase
	end

	assign porthit = (port_sel != SEL_NONE);
	assign dataout = porthit & ~iorq_n & ~rd_n; // we own the bus on an io read

	////////////////////
	// read mux
	////////////////////
	always_comb
	begin
		case (port_sel)
			SEL_FE:             dout = fe_rdata;
			SEL_7FFD, SEL_EFF7: dout = paging_rdata;
			SEL_BF:             dout = bf_rdata;
			SEL_BE:             dout = be_rdata;
			default:            dout = BUS_IDLE;
		endcase
	end

endmodule

/* source/ula_port.sv */
////////////////////
// port fe, border write and keyboard/tape read
////////////////////
`timescale 1ns/1ps

module ula_port
(
	input  logic                         zclk,
	input  logic                         rst_n,
	input  zport_pkg::port_sel_e         port_sel,
	input  logic                         port_wr,
	input  logic [zport_pkg::DATA_W-1:0] din,
	input  logic [zport_pkg::KEYS_W-1:0] keys_in,
	input  logic                         tape_read,
	output logic [zport_pkg::DATA_W-1:0] border,
	output logic [zport_pkg::DATA_W-1:0] fe_rdata
);

	import zport_pkg::*;

	logic fe_wr;

	assign fe_wr = (port_sel == SEL_FE) && port_wr;

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			border <= '0;
		else if (fe_wr)
			border <= {BORDER_FE_FILL, din[2:0]}; // only the colour bits come from the cpu
	end

	// bit 5 is the unused ear line, reads 0
	assign fe_rdata = {1'b1, tape_read, 1'b0, keys_in};

endmodule

/* source/zport_pkg.sv */
////////////////////
// constants and types shared by the z80 port modules
// port addresses, select codes and bus widths
////////////////////

package zport_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int KEYS_W = 5;

	// default depth of the rom bit reset synchronizer
	localparam int RST_SYNC_DEF = 2;

	////////////////////
	// low address bytes
	////////////////////
	localparam logic [7:0] PORT_FE = 8'hFE; // ula border, keys, tape
	localparam logic [7:0] PORT_FD = 8'hFD; // 7ffd memory paging
	localparam logic [7:0] PORT_F7 = 8'hF7; // eff7 pentagon 1m paging
	localparam logic [7:0] PORT_BF = 8'hBF; // evo config
	localparam logic [7:0] PORT_BE = 8'hBE; // config readback, nmi end

	// upper border bits forced by an fe write
	localparam logic [4:0] BORDER_FE_FILL = 5'b11110;

	// a[11:8] values picking the be readback source
	localparam logic [3:0] BE_SEL_7FFD = 4'hA;
	localparam logic [3:0] BE_SEL_EFF7 = 4'hB;

	// value seen on the data bus when nothing drives it
	localparam logic [DATA_W-1:0] BUS_IDLE = 8'hFF;

	// target port of the current access
	typedef enum logic [2:0]
	{
		SEL_NONE = 3'd0,
		SEL_FE   = 3'd1,
		SEL_7FFD = 3'd2,
		SEL_EFF7 = 3'd3,
		SEL_BF   = 3'd4,
		SEL_BE   = 3'd5
	} port_sel_e;

endpackage

/* source/zports_top.sv */
////////////////////
// z80 port block top, strobes + decoder + port peers
////////////////////
`timescale 1ns/1ps

module zports_top
#(
	parameter int RST_SYNC_STAGES = zport_pkg::RST_SYNC_DEF
)
(
	input  logic                         zclk,
	input  logic                         rst_n,
	input  logic [zport_pkg::ADDR_W-1:0] a,
	input  logic [zport_pkg::DATA_W-1:0] din,
	input  logic                         iorq_n,
	input  logic                         rd_n,
	input  logic                         wr_n,
	input  logic                         dos,
	input  logic [zport_pkg::KEYS_W-1:0] keys_in,
	input  logic                         tape_read,
	input  logic                         rstrom,
	output logic [zport_pkg::DATA_W-1:0] dout,
	output logic                         dataout,
	output logic                         porthit,
	output logic [zport_pkg::DATA_W-1:0] border,
	output logic [zport_pkg::DATA_W-1:0] p7ffd,
	output logic [zport_pkg::DATA_W-1:0] peff7,
	output logic [5:0]                   pent1m_page,
	output logic                         romrw_en,
	output logic                         fntw_en,
	output logic                         set_nmi
);

	import zport_pkg::*;

	port_sel_e         port_sel;
	logic              port_wr;
	logic              shadow;
	logic [DATA_W-1:0] fe_rdata;
	logic [DATA_W-1:0] paging_rdata;
	logic [DATA_W-1:0] bf_rdata;
	logic [DATA_W-1:0] be_rdata;
	logic [DATA_W-1:0] p7ffd_raw;
	logic [DATA_W-1:0] peff7_raw;

	io_strobe u_strobe
	(
		.zclk    (zclk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.port_wr (port_wr),
		.port_rd ()         // no read side effects in these ports
	);

	port_decode u_decode
	(
		.a            (a),
		.iorq_n       (iorq_n),
		.rd_n         (rd_n),
		.shadow       (shadow),
		.fe_rdata     (fe_rdata),
		.paging_rdata (paging_rdata),
		.bf_rdata     (bf_rdata),
		.be_rdata     (be_rdata),
		.port_sel     (port_sel),
		.porthit      (porthit),
		.dataout      (dataout),
		.dout         (dout)
	);

	ula_port u_ula
	(
		.zclk      (zclk),
		.rst_n     (rst_n),
		.port_sel  (port_sel),
		.port_wr   (port_wr),
		.din       (din),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.border    (border),
		.fe_rdata  (fe_rdata)
	);

	paging_ports #(.RST_SYNC_STAGES(RST_SYNC_STAGES)) u_paging
	(
		.zclk         (zclk),
		.rst_n        (rst_n),
		.port_sel     (port_sel),
		.port_wr      (port_wr),
		.din          (din),
		.rstrom       (rstrom),
		.p7ffd        (p7ffd),
		.peff7        (peff7),
		.p7ffd_raw    (p7ffd_raw),
		.peff7_raw    (peff7_raw),
		.pent1m_page  (pent1m_page),
		.paging_rdata (paging_rdata)
	);

	evo_config_port u_config
	(
		.zclk      (zclk),
		.rst_n     (rst_n),
		.port_sel  (port_sel),
		.port_wr   (port_wr),
		.din       (din),
		.dos       (dos),
		.a_hi      (a[11:8]),
		.p7ffd_raw (p7ffd_raw),
		.peff7_raw (peff7_raw),
		.shadow    (shadow),
		.romrw_en  (romrw_en),
		.fntw_en   (fntw_en),
		.set_nmi   (set_nmi),
		.bf_rdata  (bf_rdata),
		.be_rdata  (be_rdata)
	);

endmodule

/* tb/zports_stim.txt */
# op (W write, R read), address, data, keys, dos, output to check, expected value
# numbers in hex; a read checks dout with a port hit, or no hit when the check is miss
W 00FE 05 00 0 border F5
W 00FE FA 00 0 border F2
R 00FE 00 15 0 dout   D5
R FEFE 00 0A 0 dout   CA
W 7FFD 13 00 0 p7ffd  13
W 7FFD C6 00 0 page   36
W EFF7 01 00 0 peff7  01
R 7FFD 00 00 0 dout   FF
R 0ABE 00 00 0 dout   C6
R 0BBE 00 00 0 dout   01
R 0CBE 00 00 0 dout   FF
W 7FFD 20 00 0 p7ffd  20
W EFF7 F5 00 0 peff7  B1
W 7FFD 17 00 0 p7ffd  00
W 7FFD 07 00 0 page   08
R 0ABE 00 00 0 dout   20
W EFF7 00 00 0 peff7  00
W 7FFD 05 00 0 p7ffd  05
W 00BF 0E 00 0 romrw  01
R 00BF 00 00 0 dout   0E
W 00BF 0A 00 0 fntw   00
W 00BE 00 00 0 nmi    00
W 00BE FF 00 0 nmi    00
W EFF7 11 00 1 peff7  00
W 00BF 01 00 0 nmi    00
W EFF7 11 00 0 peff7  00
R 00BF 00 00 0 dout   01
W 00BF 00 00 0 romrw  00
W EFF7 11 00 0 peff7  11
R 1234 00 00 0 miss   FF
R BFFD 00 00 0 miss   FF

/* tb/zports_tb.sv */
////////////////////
// testbench for the z80 port block
// runs the bus operations of the stim file and checks the outputs
////////////////////
`timescale 1ns/1ps

module zports_tb;

	localparam string STIM_FILE = "tb/zports_stim.txt";

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic        rstrom;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [7:0]  border;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic [5:0]  pent1m_page;
	logic        romrw_en;
	logic        fntw_en;
	logic        set_nmi;

	// one entry per stim line
	string       op_q[$];
	string       chk_q[$];
	logic [15:0] addr_q[$];
	logic [7:0]  data_q[$];
	logic [4:0]  keys_q[$];
	logic        dos_q[$];
	logic [7:0]  exp_q[$];

	int          errors = 0;
	int          cycles = 0;
	int          limit = 100000; // replaced once the stim file is loaded
	int          fd;
	int          n_fields;
	string       line;
	string       f_op;
	string       f_chk;
	logic [15:0] f_addr;
	logic [7:0]  f_data;
	logic [4:0]  f_keys;
	logic        f_dos;
	logic [7:0]  f_exp;

	zports_top #(.RST_SYNC_STAGES(2)) uut
	(
		.zclk        (zclk),
		.rst_n       (rst_n),
		.a           (a),
		.din         (din),
		.iorq_n      (iorq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.dos         (dos),
		.keys_in     (keys_in),
		.tape_read   (tape_read),
		.rstrom      (rstrom),
		.dout        (dout),
		.dataout     (dataout),
		.porthit     (porthit),
		.border      (border),
		.p7ffd       (p7ffd),
		.peff7       (peff7),
		.pent1m_page (pent1m_page),
		.romrw_en    (romrw_en),
		.fntw_en     (fntw_en),
		.set_nmi     (set_nmi)
	);

	always #50 zclk = ~zclk;

	always @(posedge zclk)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout, the run did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task compare_value(input string name, input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected)
		begin
			errors = errors + 1;
			$display("error at %0t ns: %s expected %02h, got %02h", $time, name, expected, actual);
		end
	endtask

	// register output named by a write line
	task read_output(input string name, output logic [7:0] value, output bit known);
		known = 1'b1;
		value = 8'h00;
		if (name == "border")
			value = border;
		else if (name == "p7ffd")
			value = p7ffd;
		else if (name == "peff7")
			value = peff7;
		else if (name == "page")
			value = {2'b00, pent1m_page};
		else if (name == "romrw")
			value = {7'b0, romrw_en};
		else if (name == "fntw")
			value = {7'b0, fntw_en};
		else if (name == "nmi")
			value = {7'b0, set_nmi};
		else
			known = 1'b0;
	endtask

	// starts and ends 5 ns after a rising edge
	task run_op(input int i);
		logic [7:0] act;
		bit         known;
		bit         hit;
		begin
			hit     = (chk_q[i] != "miss");
			a       = addr_q[i];
			din     = data_q[i];
			keys_in = keys_q[i];
			dos     = dos_q[i];
			iorq_n  = 1'b0;
			if (op_q[i] == "W")
				wr_n = 1'b0;
			else
				rd_n = 1'b0;
			repeat (3) @(posedge zclk);
			#5;
			if (op_q[i] == "R")
			begin
				compare_value("dout", exp_q[i], dout);
				compare_value("porthit", {7'b0, hit}, {7'b0, porthit});
				compare_value("dataout", {7'b0, hit}, {7'b0, dataout});
			end
			iorq_n = 1'b1;
			rd_n   = 1'b1;
			wr_n   = 1'b1;
			repeat (2) @(posedge zclk);
			#5;
			if (op_q[i] == "W")
			begin
				read_output(chk_q[i], act, known);
				if (known)
					compare_value(chk_q[i], exp_q[i], act);
				else
				begin
					errors = errors + 1;
					$display("stim line %0d names an unknown output %s", i, chk_q[i]);
				end
			end
		end
	endtask

	initial
	begin
		zclk      = 1'b0;
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = 5'h00;
		tape_read = 1'b1;
		rstrom    = 1'b0;

		////////////////////
		// load stimulus
		////////////////////
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			errors = errors + 1;
			$display("could not open the stimulus file %s", STIM_FILE);
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				n_fields = $sscanf(line, "%s %h %h %h %h %s %h",
					f_op, f_addr, f_data, f_keys, f_dos, f_chk, f_exp);
				if (n_fields == 7) // comment and blank lines fall out here
				begin
					op_q.push_back(f_op);
					addr_q.push_back(f_addr);
					data_q.push_back(f_data);
					keys_q.push_back(f_keys);
					dos_q.push_back(f_dos);
					chk_q.push_back(f_chk);
					exp_q.push_back(f_exp);
				end
			end
			$fclose(fd);
			if (op_q.size() == 0)
			begin
				errors = errors + 1;
				$display("the stimulus file %s holds no bus operations", STIM_FILE);
			end
		end
		limit = 6 * op_q.size() + 20;

		repeat (2) @(posedge zclk);
		#5;
		rst_n = 1'b1;

		// reset values
		compare_value("border", 8'h00, border);
		compare_value("p7ffd", 8'h00, p7ffd);
		compare_value("peff7", 8'h00, peff7);
		compare_value("set_nmi", 8'h00, {7'b0, set_nmi});

		for (int i = 0; i < op_q.size(); i++)
			run_op(i);

		$display("%0d operations run, %0d errors", op_q.size(), errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
